//--- logic/frontEnd_macros.svh
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// Data and address width
`define XLEN 32

// Canonical NOP (add x0,x0,x0)
`define NOP_INSTR 32'h0000_0033

// Instruction memory word address width
`define IMEM_AW 8

`endif

//--- logic/rvCorePkg.sv
package rvCorePkg;

	// RV32 major opcodes
	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opOpImm  = 7'b0010011,
		opOp     = 7'b0110011,
		opSystem = 7'b1110011,
		opFence  = 7'b0001111
	} opcodeT;

	// Target functional unit
	typedef enum logic [2:0] {
		fnAlu,
		fnBranch,
		fnLsu,
		fnMulDiv,
		fnCsr,
		fnNone
	} fnUnitT;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd
	} aluOpT;

	// Load and store widths
	typedef enum logic [3:0] {
		memNone,
		memLb,
		memLh,
		memLw,
		memLbu,
		memLhu,
		memSb,
		memSh,
		memSw
	} memOpT;

	// M extension
	typedef enum logic [3:0] {
		mdNone,
		mdMul,
		mdMulh,
		mdMulhsu,
		mdMulhu,
		mdDiv,
		mdDivu,
		mdRem,
		mdRemu
	} mulDivOpT;

	typedef enum logic [1:0] {
		pcNext,		// Sequential
		pcBranch,	// Conditional target
		pcJal,		// pc-relative jump
		pcJalr		// Register-indirect jump
	} pcSelT;

endpackage

//--- logic/fetchStage.sv
`timescale 1ns/1ps
`include "frontEnd_macros.svh"

module fetchStage (
	input  logic                clk,
	input  logic                nrst,
	input  logic                holdFetch,	// From decode
	input  logic                redirect,	// From execute
	input  logic [`XLEN-1:0]    redirectPc,
	input  logic                imemWe,		// Memory load port
	input  logic [`IMEM_AW-1:0] imemAddr,
	input  logic [`XLEN-1:0]    imemData,
	output logic [`XLEN-1:0]    pc2,
	output logic [`XLEN-1:0]    instr2,
	output logic                addrMisaligned2
);

	// Word-addressed instruction store
	logic [`XLEN-1:0] imem [0:(1 << `IMEM_AW)-1];
	logic [`IMEM_AW-1:0] wordAddr;

	// Load port
	always_ff @(posedge clk)
	begin
		if (imemWe)
			imem[imemAddr] <= imemData;
	end

	// Program counter
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pc2             <= '0;
			addrMisaligned2 <= 1'b0;
		end
		else if (redirect)	// Wins over hold
		begin
			pc2             <= {redirectPc[`XLEN-1:2], 2'b00};
			addrMisaligned2 <= |redirectPc[1:0];	// Flag rides with target word
		end
		else if (!holdFetch)
		begin
			pc2             <= pc2 + `XLEN'd4;
			addrMisaligned2 <= 1'b0;
		end
	end

	// Drop byte offset for the word index
	assign wordAddr = pc2[`IMEM_AW+1:2];
	assign instr2   = imem[wordAddr];	// Async read

	// Fetch pc is always word aligned
	pcAligned: assert property (@(posedge clk) disable iff (!nrst)
		pc2[1:0] == 2'b00)
		else $error("fetch pc not word aligned: %h", pc2);

endmodule

//--- logic/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input  rvCorePkg::opcodeT   opcode,
	input  logic [2:0]          funct3,
	input  logic [6:0]          funct7,
	input  logic [11:0]         funct12,
	input  logic                rs1Zero,	// rs1 or uimm field is zero
	input  logic                exceptionPending,
	input  logic                tsr,		// Trap sret
	output rvCorePkg::pcSelT    pcSelect,
	output logic                regWe,
	output logic [1:0]          bSel,		// 00 rs2, 01 I imm, 10 S imm, 11 U imm
	output rvCorePkg::aluOpT    aluFn,
	output rvCorePkg::fnUnitT   fnUnit,
	output logic                bneq,		// Invert branch compare
	output logic                btype,
	output logic                jr,
	output logic                j,
	output rvCorePkg::memOpT    memOp,
	output rvCorePkg::mulDivOpT mulDivOp,
	output logic                lui,
	output logic                auipc,
	output logic                ecall,
	output logic                ebreak,
	output logic                mret,
	output logic                sret,
	output logic                uret,
	output logic                illegalInstr,
	output logic                csrWe
);
	import rvCorePkg::*;

	logic weRaw;		// Before exception mask
	logic csrWeRaw;

	// ALU op shared by OP and OP-IMM
	function automatic aluOpT aluBase(input logic [2:0] f3);
		case (f3)
			3'b000:  return aluAdd;
			3'b001:  return aluSll;
			3'b010:  return aluSlt;
			3'b011:  return aluSltu;
			3'b100:  return aluXor;
			3'b101:  return aluSrl;
			3'b110:  return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	always_comb
	begin
		pcSelect     = pcNext;
		weRaw        = 1'b0;
		bSel         = 2'b00;
		aluFn        = aluAdd;
		fnUnit       = fnNone;
		bneq         = 1'b0;
		btype        = 1'b0;
		jr           = 1'b0;
		j            = 1'b0;
		memOp        = memNone;
		mulDivOp     = mdNone;
		lui          = 1'b0;
		auipc        = 1'b0;
		ecall        = 1'b0;
		ebreak       = 1'b0;
		mret         = 1'b0;
		sret         = 1'b0;
		uret         = 1'b0;
		illegalInstr = 1'b0;
		csrWeRaw     = 1'b0;
		case (opcode)
			opLui:
			begin
				weRaw  = 1'b1;
				lui    = 1'b1;
				fnUnit = fnAlu;
				bSel   = 2'b11;
			end
			opAuipc:
			begin
				weRaw  = 1'b1;
				auipc  = 1'b1;
				fnUnit = fnAlu;
				bSel   = 2'b11;
			end
			opJal:
			begin
				weRaw    = 1'b1;	// Link register
				j        = 1'b1;
				fnUnit   = fnBranch;
				pcSelect = pcJal;
			end
			opJalr:
			begin
				weRaw        = 1'b1;
				jr           = 1'b1;
				fnUnit       = fnBranch;
				pcSelect     = pcJalr;
				bSel         = 2'b01;
				illegalInstr = (funct3 != 3'b000);
			end
			opBranch:
			begin
				btype        = 1'b1;
				fnUnit       = fnBranch;
				pcSelect     = pcBranch;
				bneq         = funct3[0];	// bne, bge, bgeu
				aluFn        = funct3[2] ? (funct3[1] ? aluSltu : aluSlt) : aluSub;
				illegalInstr = (funct3[2:1] == 2'b01);
			end
			opLoad:
			begin
				weRaw  = 1'b1;
				fnUnit = fnLsu;
				bSel   = 2'b01;
				case (funct3)
					3'b000:  memOp = memLb;
					3'b001:  memOp = memLh;
					3'b010:  memOp = memLw;
					3'b100:  memOp = memLbu;
					3'b101:  memOp = memLhu;
					default: illegalInstr = 1'b1;
				endcase
			end
			opStore:
			begin
				fnUnit = fnLsu;
				bSel   = 2'b10;
				case (funct3)
					3'b000:  memOp = memSb;
					3'b001:  memOp = memSh;
					3'b010:  memOp = memSw;
					default: illegalInstr = 1'b1;
				endcase
			end
			opOpImm:
			begin
				weRaw  = 1'b1;
				fnUnit = fnAlu;
				bSel   = 2'b01;
				aluFn  = aluBase(funct3);
				if (funct3 == 3'b101 && funct7 == 7'b0100000)
					aluFn = aluSra;	// srai
				else if (funct3[1:0] == 2'b01 && funct7 != 7'b0000000)
					illegalInstr = 1'b1;	// Bad shift encoding
			end
			opOp:
			begin
				weRaw  = 1'b1;
				fnUnit = fnAlu;
				if (funct7 == 7'b0000001)
				begin
					fnUnit = fnMulDiv;
					case (funct3)
						3'b000:  mulDivOp = mdMul;
						3'b001:  mulDivOp = mdMulh;
						3'b010:  mulDivOp = mdMulhsu;
						3'b011:  mulDivOp = mdMulhu;
						3'b100:  mulDivOp = mdDiv;
						3'b101:  mulDivOp = mdDivu;
						3'b110:  mulDivOp = mdRem;
						default: mulDivOp = mdRemu;
					endcase
				end
				else if (funct7 == 7'b0000000)
					aluFn = aluBase(funct3);
				else if (funct7 == 7'b0100000 && funct3 == 3'b000)
					aluFn = aluSub;
				else if (funct7 == 7'b0100000 && funct3 == 3'b101)
					aluFn = aluSra;
				else
					illegalInstr = 1'b1;
			end
			opFence:
				illegalInstr = (funct3[2:1] != 2'b00);	// fence and fence.i only
			opSystem:
			begin
				if (funct3 == 3'b000)
				begin
					case (funct12)
						12'h000: ecall  = 1'b1;
						12'h001: ebreak = 1'b1;
						12'h002: uret   = 1'b1;
						12'h102:
						begin
							sret         = !tsr;
							illegalInstr = tsr;	// Trapped in S-mode
						end
						12'h302: mret = 1'b1;
						default: illegalInstr = 1'b1;
					endcase
				end
				else if (funct3 == 3'b100)
					illegalInstr = 1'b1;
				else
				begin
					weRaw    = 1'b1;	// Old CSR value to rd
					fnUnit   = fnCsr;
					csrWeRaw = !(funct3[1] && rs1Zero);	// csrrs/c with x0 only read
				end
			end
			default: illegalInstr = 1'b1;
		endcase

		// Illegal word leaves only the flag
		if (illegalInstr)
		begin
			pcSelect = pcNext;
			weRaw    = 1'b0;
			bSel     = 2'b00;
			aluFn    = aluAdd;
			fnUnit   = fnNone;
			bneq     = 1'b0;
			btype    = 1'b0;
			jr       = 1'b0;
			j        = 1'b0;
			memOp    = memNone;
			mulDivOp = mdNone;
			lui      = 1'b0;
			auipc    = 1'b0;
			ecall    = 1'b0;
			ebreak   = 1'b0;
			uret     = 1'b0;
			sret     = 1'b0;
			mret     = 1'b0;
			csrWeRaw = 1'b0;
		end
	end

	// No architectural writes behind a pending trap
	assign regWe = weRaw & ~exceptionPending;
	assign csrWe = csrWeRaw & ~exceptionPending;

	// Execute sees a single control transfer kind
	always_comb
	begin
		assert final ($onehot0({j, jr, btype}))
			else $error("more than one of j, jr, btype set");
	end

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/1ps
`include "frontEnd_macros.svh"

module decodeStage (
	input  logic                clk,
	input  logic                nrst,
	input  logic [`XLEN-1:0]    pc2,
	input  logic [`XLEN-1:0]    instr2,
	input  logic                addrMisaligned2,
	input  logic                stall,		// Scoreboard hold
	input  logic                memBusy,
	input  logic                discard,	// Flush from execute
	input  logic                exceptionPending,
	input  logic                tsr,
	output logic                holdFetch,
	output logic [4:0]          rs1,
	output logic [4:0]          rs2,
	output logic [4:0]          rd3,
	output logic [4:0]          shamt,
	output logic [`XLEN-1:0]    iImm3,
	output logic [`XLEN-1:0]    bImm3,
	output logic [`XLEN-1:0]    jImm3,
	output logic [`XLEN-1:0]    uImm3,
	output logic [`XLEN-1:0]    sImm3,
	output logic [`XLEN-1:0]    pc3,
	output logic [6:0]          opcode3,
	output logic [2:0]          funct3_3,
	output logic [11:0]         csrAddr3,
	output logic [`XLEN-1:0]    csrImm3,
	output logic                addrMisaligned3,
	output rvCorePkg::pcSelT    pcSelect3,
	output logic                regWe3,
	output logic [1:0]          bSel3,
	output rvCorePkg::aluOpT    aluFn3,
	output rvCorePkg::fnUnitT   fnUnit3,
	output logic                bneq3,
	output logic                btype3,
	output logic                jr3,
	output logic                j3,
	output rvCorePkg::memOpT    memOp3,
	output rvCorePkg::mulDivOpT mulDivOp3,
	output logic                lui3,
	output logic                auipc3,
	output logic                ecall3,
	output logic                ebreak3,
	output logic                mret3,
	output logic                sret3,
	output logic                uret3,
	output logic                illegalInstr3,
	output logic                csrWe3
);
	import rvCorePkg::*;

	logic [`XLEN-1:0] instrReg;	// Instruction in decode
	opcodeT opcode;

	// Flush beats back-pressure
	assign holdFetch = (stall | memBusy) & ~discard;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			instrReg        <= `NOP_INSTR;
			pc3             <= '0;
			addrMisaligned3 <= 1'b0;
		end
		else if (discard)
		begin
			instrReg        <= `NOP_INSTR;	// pc3 stays put
			addrMisaligned3 <= 1'b0;
		end
		else if (!holdFetch)
		begin
			instrReg        <= instr2;
			pc3             <= pc2;
			addrMisaligned3 <= addrMisaligned2;
		end
	end

	// Register fields
	assign rs1   = instrReg[19:15];
	assign rs2   = instrReg[24:20];
	assign rd3   = instrReg[11:7];
	assign shamt = instrReg[24:20];

	// Sign-extended immediates
	assign iImm3 = {{(`XLEN-12){instrReg[31]}}, instrReg[31:20]};
	assign sImm3 = {{(`XLEN-12){instrReg[31]}}, instrReg[31:25], instrReg[11:7]};
	assign bImm3 = {{(`XLEN-13){instrReg[31]}}, instrReg[31], instrReg[7],
		instrReg[30:25], instrReg[11:8], 1'b0};
	assign jImm3 = {{(`XLEN-21){instrReg[31]}}, instrReg[31], instrReg[19:12],
		instrReg[20], instrReg[30:21], 1'b0};
	assign uImm3 = {instrReg[31:12], 12'b0};	// Already full width

	// CSR unit fields
	assign funct3_3 = instrReg[14:12];
	assign csrAddr3 = instrReg[31:20];
	assign csrImm3  = {{(`XLEN-5){1'b0}}, instrReg[19:15]};	// Zero-extended uimm

	assign opcode3 = instrReg[6:0];
	assign opcode  = opcodeT'(instrReg[6:0]);	// Unknown codes go to default arm

	instrDecoder decoder_i (
		.opcode           (opcode),
		.funct3           (instrReg[14:12]),
		.funct7           (instrReg[31:25]),
		.funct12          (instrReg[31:20]),
		.rs1Zero          (instrReg[19:15] == 5'd0),
		.exceptionPending (exceptionPending),
		.tsr              (tsr),
		.pcSelect         (pcSelect3),
		.regWe            (regWe3),
		.bSel             (bSel3),
		.aluFn            (aluFn3),
		.fnUnit           (fnUnit3),
		.bneq             (bneq3),
		.btype            (btype3),
		.jr               (jr3),
		.j                (j3),
		.memOp            (memOp3),
		.mulDivOp         (mulDivOp3),
		.lui              (lui3),
		.auipc            (auipc3),
		.ecall            (ecall3),
		.ebreak           (ebreak3),
		.mret             (mret3),
		.sret             (sret3),
		.uret             (uret3),
		.illegalInstr     (illegalInstr3),
		.csrWe            (csrWe3)
	);

	// Discard flushes even while stalled
	discardWins: assert property (@(posedge clk) disable iff (!nrst)
		discard && (stall || memBusy) |=> instrReg == `NOP_INSTR && $stable(pc3))
		else $error("discard did not override hold");

endmodule

//--- logic/frontEnd.sv
`timescale 1ns/1ps
`include "frontEnd_macros.svh"

module frontEnd (
	input  logic                clk,
	input  logic                nrst,
	input  logic                redirect,
	input  logic [`XLEN-1:0]    redirectPc,
	input  logic                imemWe,
	input  logic [`IMEM_AW-1:0] imemAddr,
	input  logic [`XLEN-1:0]    imemData,
	input  logic                stall,
	input  logic                memBusy,
	input  logic                discard,
	input  logic                exceptionPending,
	input  logic                tsr,
	output logic [4:0]          rs1,
	output logic [4:0]          rs2,
	output logic [4:0]          rd3,
	output logic [4:0]          shamt,
	output logic [`XLEN-1:0]    iImm3,
	output logic [`XLEN-1:0]    bImm3,
	output logic [`XLEN-1:0]    jImm3,
	output logic [`XLEN-1:0]    uImm3,
	output logic [`XLEN-1:0]    sImm3,
	output logic [`XLEN-1:0]    pc3,
	output logic [6:0]          opcode3,
	output logic [2:0]          funct3_3,
	output logic [11:0]         csrAddr3,
	output logic [`XLEN-1:0]    csrImm3,
	output logic                addrMisaligned3,
	output rvCorePkg::pcSelT    pcSelect3,
	output logic                regWe3,
	output logic [1:0]          bSel3,
	output rvCorePkg::aluOpT    aluFn3,
	output rvCorePkg::fnUnitT   fnUnit3,
	output logic                bneq3,
	output logic                btype3,
	output logic                jr3,
	output logic                j3,
	output rvCorePkg::memOpT    memOp3,
	output rvCorePkg::mulDivOpT mulDivOp3,
	output logic                lui3,
	output logic                auipc3,
	output logic                ecall3,
	output logic                ebreak3,
	output logic                mret3,
	output logic                sret3,
	output logic                uret3,
	output logic                illegalInstr3,
	output logic                csrWe3
);

	// Fetch to decode
	logic [`XLEN-1:0] pc2;
	logic [`XLEN-1:0] instr2;
	logic             addrMisaligned2;
	logic             holdFetch;	// Back from decode

	fetchStage fetch_i (
		.clk             (clk),
		.nrst            (nrst),
		.holdFetch       (holdFetch),
		.redirect        (redirect),
		.redirectPc      (redirectPc),
		.imemWe          (imemWe),
		.imemAddr        (imemAddr),
		.imemData        (imemData),
		.pc2             (pc2),
		.instr2          (instr2),
		.addrMisaligned2 (addrMisaligned2)
	);

	decodeStage decode_i (
		.clk              (clk),
		.nrst             (nrst),
		.pc2              (pc2),
		.instr2           (instr2),
		.addrMisaligned2  (addrMisaligned2),
		.stall            (stall),
		.memBusy          (memBusy),
		.discard          (discard),
		.exceptionPending (exceptionPending),
		.tsr              (tsr),
		.holdFetch        (holdFetch),
		.rs1              (rs1),
		.rs2              (rs2),
		.rd3              (rd3),
		.shamt            (shamt),
		.iImm3            (iImm3),
		.bImm3            (bImm3),
		.jImm3            (jImm3),
		.uImm3            (uImm3),
		.sImm3            (sImm3),
		.pc3              (pc3),
		.opcode3          (opcode3),
		.funct3_3         (funct3_3),
		.csrAddr3         (csrAddr3),
		.csrImm3          (csrImm3),
		.addrMisaligned3  (addrMisaligned3),
		.pcSelect3        (pcSelect3),
		.regWe3           (regWe3),
		.bSel3            (bSel3),
		.aluFn3           (aluFn3),
		.fnUnit3          (fnUnit3),
		.bneq3            (bneq3),
		.btype3           (btype3),
		.jr3              (jr3),
		.j3               (j3),
		.memOp3           (memOp3),
		.mulDivOp3        (mulDivOp3),
		.lui3             (lui3),
		.auipc3           (auipc3),
		.ecall3           (ecall3),
		.ebreak3          (ebreak3),
		.mret3            (mret3),
		.sret3            (sret3),
		.uret3            (uret3),
		.illegalInstr3    (illegalInstr3),
		.csrWe3           (csrWe3)
	);

endmodule

//--- verification/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected control bundle of one decoded word
typedef struct packed {
	pcSelT    pcSel;
	logic     regWe;
	logic [1:0] bSel;
	aluOpT    aluFn;
	fnUnitT   fnUnit;
	logic     bneq;
	logic     btype;
	logic     jr;
	logic     j;
	memOpT    memOp;
	mulDivOpT mulDivOp;
	logic     lui;
	logic     auipc;
	logic     ecall;
	logic     ebreak;
	logic     mret;
	logic     sret;
	logic     uret;
	logic     illegal;
	logic     csrWe;
} ctrlT;

// Opcode mix, OP and OP-IMM weighted up
function automatic logic [6:0] pickOpcode(input logic [3:0] sel);
	case (sel)
		4'd0:    return opLui;
		4'd1:    return opAuipc;
		4'd2:    return opJal;
		4'd3:    return opJalr;
		4'd4:    return opBranch;
		4'd5:    return opLoad;
		4'd6:    return opStore;
		4'd7:    return opOpImm;
		4'd8:    return opOp;
		4'd9:    return opSystem;
		4'd10:   return opFence;
		4'd11:   return 7'b1111111;	// Not an RV32 opcode
		4'd12,
		4'd13:   return opOp;
		default: return opOpImm;
	endcase
endfunction

// Random word pushed toward legal encodings
function automatic logic [31:0] encodeRandom(input logic [31:0] r, input logic [31:0] s);
	logic [31:0] w;
	w = r;
	w[6:0] = pickOpcode(s[3:0]);
	case (s[5:4])	// funct7 for base, alternate and M forms
		2'd0:    w[31:25] = 7'b0000000;
		2'd1:    w[31:25] = 7'b0100000;
		2'd2:    w[31:25] = 7'b0000001;
		default: w[31:25] = r[31:25];
	endcase
	if (w[6:0] == opJalr && s[6])
		w[14:12] = 3'b000;
	if (w[6:0] == opSystem && s[7])
	begin
		w[14:12] = 3'b000;	// Privileged group
		case (s[10:8])
			3'd0:    w[31:20] = 12'h000;
			3'd1:    w[31:20] = 12'h001;
			3'd2:    w[31:20] = 12'h002;
			3'd3:    w[31:20] = 12'h102;
			3'd4:    w[31:20] = 12'h302;
			default: w[31:20] = 12'h105;	// wfi, unsupported here
		endcase
	end
	if (s[11])
		w[19:15] = 5'd0;	// Read-only CSR forms
	return w;
endfunction

// Immediates per the RV32 formats
function automatic logic [31:0] immI(input logic [31:0] w);
	return 32'($signed(w[31:20]));
endfunction

function automatic logic [31:0] immS(input logic [31:0] w);
	return 32'($signed({w[31:25], w[11:7]}));
endfunction

function automatic logic [31:0] immB(input logic [31:0] w);
	return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
endfunction

function automatic logic [31:0] immJ(input logic [31:0] w);
	return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
endfunction

function automatic logic [31:0] immU(input logic [31:0] w);
	return {w[31:12], 12'h000};
endfunction

function automatic aluOpT aluForFunct3(input logic [2:0] f3);
	case (f3)
		3'd0:    return aluAdd;
		3'd1:    return aluSll;
		3'd2:    return aluSlt;
		3'd3:    return aluSltu;
		3'd4:    return aluXor;
		3'd5:    return aluSrl;
		3'd6:    return aluOr;
		default: return aluAnd;
	endcase
endfunction

function automatic ctrlT decodeRef(input logic [31:0] w, input logic exPend, input logic tsrIn);
	ctrlT c;
	logic [2:0] f3;
	logic [6:0] f7;
	logic bad;
	f3 = w[14:12];
	f7 = w[31:25];
	c = '0;
	c.fnUnit = fnNone;
	bad = 1'b0;
	case (w[6:0])
		opLui, opAuipc:
		begin
			c.regWe = 1'b1;
			c.lui = w[5];	// Only bit apart
			c.auipc = !w[5];
			c.fnUnit = fnAlu;
			c.bSel = 2'b11;
		end
		opJal:
		begin
			c.regWe = 1'b1;
			c.j = 1'b1;
			c.fnUnit = fnBranch;
			c.pcSel = pcJal;
		end
		opJalr:
		begin
			bad = (f3 != 3'd0);
			c.regWe = 1'b1;
			c.jr = 1'b1;
			c.fnUnit = fnBranch;
			c.pcSel = pcJalr;
			c.bSel = 2'b01;
		end
		opBranch:
		begin
			bad = (f3 == 3'd2 || f3 == 3'd3);
			c.btype = 1'b1;
			c.fnUnit = fnBranch;
			c.pcSel = pcBranch;
			c.bneq = (f3 == 3'd1 || f3 == 3'd5 || f3 == 3'd7);	// bne, bge, bgeu
			case (f3)
				3'd4, 3'd5: c.aluFn = aluSlt;
				3'd6, 3'd7: c.aluFn = aluSltu;
				default:    c.aluFn = aluSub;
			endcase
		end
		opLoad:
		begin
			c.regWe = 1'b1;
			c.fnUnit = fnLsu;
			c.bSel = 2'b01;
			case (f3)
				3'd0:    c.memOp = memLb;
				3'd1:    c.memOp = memLh;
				3'd2:    c.memOp = memLw;
				3'd4:    c.memOp = memLbu;
				3'd5:    c.memOp = memLhu;
				default: bad = 1'b1;
			endcase
		end
		opStore:
		begin
			c.fnUnit = fnLsu;
			c.bSel = 2'b10;
			case (f3)
				3'd0:    c.memOp = memSb;
				3'd1:    c.memOp = memSh;
				3'd2:    c.memOp = memSw;
				default: bad = 1'b1;
			endcase
		end
		opOpImm:
		begin
			c.regWe = 1'b1;
			c.fnUnit = fnAlu;
			c.bSel = 2'b01;
			c.aluFn = aluForFunct3(f3);
			if (f3 == 3'd1)
				bad = (f7 != 7'h00);	// slli
			else if (f3 == 3'd5 && f7 == 7'h20)
				c.aluFn = aluSra;
			else if (f3 == 3'd5)
				bad = (f7 != 7'h00);
		end
		opOp:
		begin
			c.regWe = 1'b1;
			c.fnUnit = fnAlu;
			if (f7 == 7'h01)
			begin
				c.fnUnit = fnMulDiv;
				case (f3)
					3'd0:    c.mulDivOp = mdMul;
					3'd1:    c.mulDivOp = mdMulh;
					3'd2:    c.mulDivOp = mdMulhsu;
					3'd3:    c.mulDivOp = mdMulhu;
					3'd4:    c.mulDivOp = mdDiv;
					3'd5:    c.mulDivOp = mdDivu;
					3'd6:    c.mulDivOp = mdRem;
					default: c.mulDivOp = mdRemu;
				endcase
			end
			else if (f7 == 7'h00)
				c.aluFn = aluForFunct3(f3);
			else if (f7 == 7'h20 && f3 == 3'd0)
				c.aluFn = aluSub;
			else if (f7 == 7'h20 && f3 == 3'd5)
				c.aluFn = aluSra;
			else
				bad = 1'b1;
		end
		opFence:
			bad = (f3 > 3'd1);
		opSystem:
		begin
			if (f3 == 3'd0)
			begin
				case (w[31:20])
					12'h000: c.ecall = 1'b1;
					12'h001: c.ebreak = 1'b1;
					12'h002: c.uret = 1'b1;
					12'h102: bad = tsrIn;	// sret trapped by tsr
					12'h302: c.mret = 1'b1;
					default: bad = 1'b1;
				endcase
				c.sret = (w[31:20] == 12'h102) && !tsrIn;
			end
			else if (f3 == 3'd4)
				bad = 1'b1;
			else
			begin
				c.regWe = 1'b1;
				c.fnUnit = fnCsr;
				c.csrWe = !((f3[1:0] == 2'd2 || f3[1:0] == 2'd3) && w[19:15] == 5'd0);
			end
		end
		default: bad = 1'b1;
	endcase
	if (bad)
	begin
		c = '0;
		c.fnUnit = fnNone;
		c.illegal = 1'b1;
	end
	c.regWe = c.regWe & ~exPend;	// Pending trap blocks writes
	c.csrWe = c.csrWe & ~exPend;
	return c;
endfunction

`endif

//--- verification/frontEndTb.sv
`timescale 1ns/1ps
`include "frontEnd_macros.svh"

module frontEndTb;
	import rvCorePkg::*;
	`include "decodeModel.svh"

	logic clk;
	logic nrst;
	logic redirect;
	logic [`XLEN-1:0] redirectPc;
	logic imemWe;
	logic [`IMEM_AW-1:0] imemAddr;
	logic [`XLEN-1:0] imemData;
	logic stall;
	logic memBusy;
	logic discard;
	logic exceptionPending;
	logic tsr;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd3;
	logic [4:0] shamt;
	logic [`XLEN-1:0] iImm3;
	logic [`XLEN-1:0] bImm3;
	logic [`XLEN-1:0] jImm3;
	logic [`XLEN-1:0] uImm3;
	logic [`XLEN-1:0] sImm3;
	logic [`XLEN-1:0] pc3;
	logic [6:0] opcode3;
	logic [2:0] funct3_3;
	logic [11:0] csrAddr3;
	logic [`XLEN-1:0] csrImm3;
	logic addrMisaligned3;
	pcSelT pcSelect3;
	logic regWe3;
	logic [1:0] bSel3;
	aluOpT aluFn3;
	fnUnitT fnUnit3;
	logic bneq3;
	logic btype3;
	logic jr3;
	logic j3;
	memOpT memOp3;
	mulDivOpT mulDivOp3;
	logic lui3;
	logic auipc3;
	logic ecall3;
	logic ebreak3;
	logic mret3;
	logic sret3;
	logic uret3;
	logic illegalInstr3;
	logic csrWe3;

	// Reference state
	logic [`XLEN-1:0] imemCopy [0:(1 << `IMEM_AW)-1];
	logic [`XLEN-1:0] modelPc;	// Fetch pc
	logic modelMis2;
	logic [`XLEN-1:0] modelInstr;	// Word held in decode
	logic [`XLEN-1:0] modelPc3;
	logic modelMis3;
	logic checkOn;
	int accepted;	// Words that entered decode
	int seed;
	int i;
	int cycles;
	int waitCount;
	logic [31:0] roll;
	logic [31:0] wordR;
	logic [31:0] wordS;
	logic jump;
	wire modelHold = (stall | memBusy) & ~discard;

	frontEnd dut_i (.*);

	always #4 clk = ~clk;

	task automatic stopRun;
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	// Full output compare against the reference
	task automatic compareAll;
		ctrlT e;
		logic [31:0] w;
		w = modelInstr;
		e = decodeRef(w, exceptionPending, tsr);
		checkVal("pc3", pc3, modelPc3);
		checkVal("addrMisaligned3", addrMisaligned3, modelMis3);
		checkVal("opcode3", opcode3, w[6:0]);
		checkVal("rs1", rs1, w[19:15]);
		checkVal("rs2", rs2, w[24:20]);
		checkVal("rd3", rd3, w[11:7]);
		checkVal("shamt", shamt, w[24:20]);
		checkVal("iImm3", iImm3, immI(w));
		checkVal("sImm3", sImm3, immS(w));
		checkVal("bImm3", bImm3, immB(w));
		checkVal("jImm3", jImm3, immJ(w));
		checkVal("uImm3", uImm3, immU(w));
		checkVal("funct3_3", funct3_3, w[14:12]);
		checkVal("csrAddr3", csrAddr3, w[31:20]);
		checkVal("csrImm3", csrImm3, {27'd0, w[19:15]});	// Zero-extended uimm
		checkVal("pcSelect3", pcSelect3, e.pcSel);
		checkVal("regWe3", regWe3, e.regWe);
		checkVal("bSel3", bSel3, e.bSel);
		checkVal("aluFn3", aluFn3, e.aluFn);
		checkVal("fnUnit3", fnUnit3, e.fnUnit);
		checkVal("bneq3", bneq3, e.bneq);
		checkVal("btype3", btype3, e.btype);
		checkVal("jr3", jr3, e.jr);
		checkVal("j3", j3, e.j);
		checkVal("memOp3", memOp3, e.memOp);
		checkVal("mulDivOp3", mulDivOp3, e.mulDivOp);
		checkVal("lui3", lui3, e.lui);
		checkVal("auipc3", auipc3, e.auipc);
		checkVal("ecall3", ecall3, e.ecall);
		checkVal("ebreak3", ebreak3, e.ebreak);
		checkVal("mret3", mret3, e.mret);
		checkVal("sret3", sret3, e.sret);
		checkVal("uret3", uret3, e.uret);
		checkVal("illegalInstr3", illegalInstr3, e.illegal);
		checkVal("csrWe3", csrWe3, e.csrWe);
	endtask

	// Cycle model of fetch pc and decode register
	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			modelPc = '0;
			modelMis2 = 1'b0;
			modelInstr = `NOP_INSTR;
			modelPc3 = '0;
			modelMis3 = 1'b0;
			accepted = 0;
		end
		else
		begin
			if (discard)
			begin
				modelInstr = `NOP_INSTR;	// pc3 unchanged
				modelMis3 = 1'b0;
			end
			else if (!modelHold)
			begin
				modelInstr = imemCopy[modelPc[`IMEM_AW+1:2]];
				modelPc3 = modelPc;
				modelMis3 = modelMis2;
				accepted++;
			end
			if (redirect)	// Beats hold
			begin
				modelPc = {redirectPc[`XLEN-1:2], 2'b00};
				modelMis2 = |redirectPc[1:0];
			end
			else if (!modelHold)
			begin
				modelPc = modelPc + 4;
				modelMis2 = 1'b0;
			end
		end
	end

	always @(negedge clk)
	begin
		if (checkOn)
			compareAll();
	end

	initial
	begin
		seed = 91134;
		clk = 1'b0;
		nrst = 1'b0;
		stall = 1'b1;	// Pipeline parked for the load
		memBusy = 1'b0;
		discard = 1'b0;
		redirect = 1'b0;
		redirectPc = '0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		exceptionPending = 1'b1;	// Keeps NOP from writing
		tsr = 1'b0;
		checkOn = 1'b0;
		repeat (3) @(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);
		checkVal("pc3", pc3, 32'd0);
		checkVal("regWe3", regWe3, 1'b0);
		checkVal("csrWe3", csrWe3, 1'b0);
		checkVal("btype3", btype3, 1'b0);
		checkVal("j3", j3, 1'b0);
		checkVal("jr3", jr3, 1'b0);
		checkVal("illegalInstr3", illegalInstr3, 1'b0);
		checkVal("ecall3", ecall3, 1'b0);
		checkVal("memOp3", memOp3, memNone);
		checkVal("mulDivOp3", mulDivOp3, mdNone);

		// Program load through the write port
		for (i = 0; i < (1 << `IMEM_AW); i++)
		begin
			@(posedge clk);
			wordR = $random(seed);
			wordS = $random(seed);
			imemCopy[i] = encodeRandom(wordR, wordS);
			imemWe <= 1'b1;
			imemAddr <= i[`IMEM_AW-1:0];
			imemData <= imemCopy[i];
			checkOn <= 1'b1;
		end
		@(posedge clk);
		imemWe <= 1'b0;
		exceptionPending <= 1'b0;

		// Random back-pressure, flushes and jumps
		cycles = 0;
		while (accepted < 600 && cycles < 5000)
		begin
			@(posedge clk);
			cycles++;
			roll = $random(seed);
			jump = (roll[9:6] == 4'd0);
			stall <= (roll[2:0] < 3'd2);
			memBusy <= (roll[5:3] == 3'd0);
			redirect <= jump;
			discard <= jump || (roll[13:10] == 4'd0);	// Flush with every jump
			redirectPc <= {22'd0, roll[25:16]};	// Any byte offset
			exceptionPending <= (roll[28:26] == 3'd0);
			tsr <= roll[29];
		end
		if (accepted < 600)
		begin
			$display("Timeout: only %0d instructions reached decode", accepted);
			stopRun();
		end

		// Unaligned jump target
		@(posedge clk);
		stall <= 1'b0;
		memBusy <= 1'b0;
		exceptionPending <= 1'b0;
		redirect <= 1'b1;
		discard <= 1'b1;
		redirectPc <= 32'h0000_0122;
		@(posedge clk);
		redirect <= 1'b0;
		discard <= 1'b0;
		waitCount = 0;
		do
		begin
			@(negedge clk);
			waitCount++;
		end
		while (addrMisaligned3 !== 1'b1 && waitCount < 16);
		if (addrMisaligned3 !== 1'b1)
		begin
			$display("Timeout: unaligned redirect never raised the misaligned flag");
			stopRun();
		end
		checkVal("pc3", pc3, 32'h0000_0120);
		@(negedge clk);
		$display("All checks passed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+logic
+incdir+verification
logic/rvCorePkg.sv
logic/fetchStage.sv
logic/instrDecoder.sv
logic/decodeStage.sv
logic/frontEnd.sv
verification/frontEndTb.sv
